// File: hw/ar_skid_pipe.sv
// two-deep register stage for the AXI read command
// in_ready is registered, so it falls one cycle after the stage fills
// the skid entry absorbs the command taken in that cycle
// in_valid may be raised without in_ready; nothing is taken until ready is high

module ar_skid_pipe
  import nocif_read_pkg::*;
(
  input  logic     nvdla_core_clk,
  input  logic     nvdla_core_rstn,
  input  logic     in_valid,
  output logic     in_ready,
  input  axi_cmd_t in_cmd,
  output logic     out_valid,
  input  logic     out_ready,
  output axi_cmd_t out_cmd
);

  logic     skid_ready_q;
  logic     skid_valid;
  axi_cmd_t skid_data;
  logic     skid_catch;
  logic     skid_ready;
  logic     skid_pipe_valid;
  axi_cmd_t skid_pipe_data;
  logic     pipe_valid;
  axi_cmd_t pipe_data;
  logic     pipe_ready_bc;

  // ======================================================================
  // skid stage
  // ======================================================================

  // taken upstream but the pipe register cannot accept it
  assign skid_catch = in_valid & skid_ready_q & ~pipe_ready_bc;

  // ready next cycle only if the skid stays empty
  assign skid_ready = skid_valid ? pipe_ready_bc : ~skid_catch;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      skid_valid   <= 1'b0;
      skid_ready_q <= 1'b1;
    end else begin
      skid_valid   <= skid_valid ? ~pipe_ready_bc : skid_catch;
      skid_ready_q <= skid_ready;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (skid_catch) begin
      skid_data <= in_cmd;
    end
  end

  assign in_ready = skid_ready_q;

  // bypass the skid while it is empty
  assign skid_pipe_valid = skid_ready_q ? in_valid : skid_valid;
  assign skid_pipe_data  = skid_ready_q ? in_cmd : skid_data;

  // ======================================================================
  // pipe register, bubble collapsing
  // ======================================================================

  // an empty register always loads
  assign pipe_ready_bc = out_ready | ~pipe_valid;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pipe_valid <= 1'b0;
    end else begin
      pipe_valid <= pipe_ready_bc ? skid_pipe_valid : 1'b1;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (pipe_ready_bc && skid_pipe_valid) begin
      pipe_data <= skid_pipe_data;
    end
  end

  assign out_valid = pipe_valid;
  assign out_cmd   = pipe_data;

endmodule

// File: hw/nocif_read_ig_cvt.sv
// ingress converter of the DRAM read path, splitter request to AXI AR
// one context queue write per accepted request, in the accept cycle
// AR leaves one cycle after accept at the earliest
// arid and arlen are zero extended; no AXI size, user or tie-off signals

module nocif_read_ig_cvt
  import nocif_read_pkg::*;
#(
  parameter bit half_atom_en = 1'b1
) (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  // splitter request
  input  logic                       spt2cvt_req_valid,
  output logic                       spt2cvt_req_ready,
  input  rd_req_t                    spt2cvt_req_pd,
  // context queue write
  output logic                       cq_wr_pvld,
  input  logic                       cq_wr_prdy,
  output logic [thread_id_width-1:0] cq_wr_thread_id,
  output cq_entry_t                  cq_wr_pd,
  // AXI read address
  output logic                       mcif2noc_axi_ar_arvalid,
  input  logic                       mcif2noc_axi_ar_arready,
  output logic [7:0]                 mcif2noc_axi_ar_arid,
  output logic [mem_addr_width-1:0]  mcif2noc_axi_ar_araddr,
  output logic [3:0]                 mcif2noc_axi_ar_arlen,
  // credit return and limit
  input  logic                       eg2ig_axi_vld,
  input  logic [7:0]                 reg2dp_rd_os_cnt
);

  axi_cmd_t axi_cmd;
  axi_cmd_t opipe_cmd;
  logic     pipe_valid;
  logic     pipe_ready;

  // ======================================================================
  // decode
  // ======================================================================

  read_cmd_decode #(
    .half_atom_en (half_atom_en)
  ) u_decode (
    .req       (spt2cvt_req_pd),
    .cmd       (axi_cmd),
    .cq_entry  (cq_wr_pd),
    .thread_id (cq_wr_thread_id)
  );

  // outstanding limit and three-way accept
  os_credit_ctrl u_credit (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .req_valid        (spt2cvt_req_valid),
    .len              (axi_cmd.len),
    .pipe_ready       (pipe_ready),
    .cq_wr_prdy       (cq_wr_prdy),
    .eg2ig_axi_vld    (eg2ig_axi_vld),
    .reg2dp_rd_os_cnt (reg2dp_rd_os_cnt),
    .req_ready        (spt2cvt_req_ready),
    .cq_wr_pvld       (cq_wr_pvld),
    .pipe_valid       (pipe_valid)
  );

  // ======================================================================
  // AR output stage
  // ======================================================================

  ar_skid_pipe u_ar_pipe (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (pipe_valid),
    .in_ready        (pipe_ready),
    .in_cmd          (axi_cmd),
    .out_valid       (mcif2noc_axi_ar_arvalid),
    .out_ready       (mcif2noc_axi_ar_arready),
    .out_cmd         (opipe_cmd)
  );

  // zero extension to the AXI port widths
  assign mcif2noc_axi_ar_arid   = {4'b0, opipe_cmd.axid};
  assign mcif2noc_axi_ar_araddr = opipe_cmd.addr;
  assign mcif2noc_axi_ar_arlen  = {2'b0, opipe_cmd.len};

endmodule

// File: hw/nocif_read_pkg.sv
// shared widths, client id table and packed payloads for the read ingress path
// address width is fixed here since every packed struct below depends on it
// all ten DMA read clients are assumed present; the id table is not configurable
// rd_req_t field order must match the splitter's packing

package nocif_read_pkg;

  // ======================================================================
  // widths
  // ======================================================================

  // memory address bits carried end to end
  localparam int mem_addr_width = 64;

  // 32-byte atom, low address bits cleared on the AXI side
  localparam int atom_log2 = 5;

  // client AXI id as seen on the request
  localparam int axid_width = 4;

  // context queue thread index
  localparam int thread_id_width = 4;

  // outstanding beat counter, room for 256 beats plus margin
  localparam int os_cnt_width = 9;

  // ======================================================================
  // client id table
  // ======================================================================

  localparam int num_read_clients = 10;

  // thread i serves the client whose axid is entry i
  // order: bdma, sdp, pdp, cdp, rubik, sdp_b, sdp_n, sdp_e, cdma_dat, cdma_wt style slots
  localparam logic [axid_width-1:0] client_axid_table [num_read_clients] = '{
    4'd0, 4'd8, 4'd9, 4'd3, 4'd2, 4'd4, 4'd1, 4'd5, 4'd7, 4'd6
  };

  // ======================================================================
  // packed payloads
  // ======================================================================

  // read request from the splitter, 75 bits
  typedef struct packed {
    logic                      ftran;
    logic                      ltran;
    logic                      odd;
    logic                      swizzle;
    logic [2:0]                size;
    logic [mem_addr_width-1:0] addr;
    logic [axid_width-1:0]     axid;
  } rd_req_t;

  // AXI read command before zero extension, 70 bits
  typedef struct packed {
    logic [axid_width-1:0]     axid;
    logic [mem_addr_width-1:0] addr;
    logic [1:0]                len;
  } axi_cmd_t;

  // context queue entry consumed by the egress side, 7 bits
  typedef struct packed {
    logic       ldrop;
    logic       fdrop;
    logic       ltran;
    logic       odd;
    logic       swizzle;
    logic [1:0] lens;
  } cq_entry_t;

endpackage

// File: hw/os_credit_ctrl.sv
// outstanding beat limiter plus the accept interlock for the ingress path
// egress credits are registered once before they reach the counter
// limit is reg2dp_rd_os_cnt + 1 beats; the register is treated as static
// egress pulses must never exceed issued beats, the counter does not saturate

module os_credit_ctrl
  import nocif_read_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       req_valid,
  input  logic [1:0] len,
  input  logic       pipe_ready,
  input  logic       cq_wr_prdy,
  input  logic       eg2ig_axi_vld,
  input  logic [7:0] reg2dp_rd_os_cnt,
  output logic       req_ready,
  output logic       cq_wr_pvld,
  output logic       pipe_valid
);

  logic                    eg_vld_d;
  logic [os_cnt_width-1:0] os_cnt;
  logic [2:0]              req_beats;
  logic [2:0]              cnt_add;
  logic [os_cnt_width:0]   os_inp_nxt;
  logic [os_cnt_width:0]   os_limit;
  logic                    os_full;
  logic                    push;

  // ======================================================================
  // full test
  // ======================================================================

  // beats this request would add, len is beats minus one
  assign req_beats = {1'b0, len} + 3'd1;

  // projected count if the presented request were taken
  assign os_inp_nxt = {1'b0, os_cnt}
                    + {{(os_cnt_width - 2){1'b0}}, (req_valid ? req_beats : 3'd0)}
                    - {{os_cnt_width{1'b0}}, eg_vld_d};

  assign os_limit = {{(os_cnt_width - 7){1'b0}}, reg2dp_rd_os_cnt} + 1'b1;
  assign os_full  = os_inp_nxt > os_limit;

  // ======================================================================
  // accept interlock
  // ======================================================================

  // each side only sees the other two conditions, so a request
  // lands in the pipe and the context queue in the same cycle
  assign req_ready  = pipe_ready & cq_wr_prdy & ~os_full;
  assign cq_wr_pvld = req_valid & pipe_ready & ~os_full;
  assign pipe_valid = req_valid & cq_wr_prdy & ~os_full;

  assign push    = pipe_valid & pipe_ready;
  assign cnt_add = push ? req_beats : 3'd0;

  // ======================================================================
  // counter
  // ======================================================================

  // egress pulse delay, one cycle
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      eg_vld_d <= 1'b0;
    end else begin
      eg_vld_d <= eg2ig_axi_vld;
    end
  end

  // add and return may coincide
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      os_cnt <= '0;
    end else if (push || eg_vld_d) begin
      os_cnt <= os_cnt + {{(os_cnt_width - 3){1'b0}}, cnt_add}
                       - {{(os_cnt_width - 1){1'b0}}, eg_vld_d};
    end
  end

endmodule

// File: hw/read_cmd_decode.sv
// purely combinational request decode, no state
// requests are expected atom aligned and must not cross a 256-byte block
// size[2:1] + inc must fit in two bits; an overflow is silently wrapped
// half_atom_en = 0 forces both drop flags low (atom equals memory width)

module read_cmd_decode
  import nocif_read_pkg::*;
#(
  parameter bit half_atom_en = 1'b1
) (
  input  rd_req_t                    req,
  output axi_cmd_t                   cmd,
  output cq_entry_t                  cq_entry,
  output logic [thread_id_width-1:0] thread_id
);

  // ======================================================================
  // alignment info
  // ======================================================================

  // extra beat for a single swizzled odd-size transfer
  logic       inc;
  // start sits on the upper half of a 64-byte word
  logic       stt_half;
  // end lands on the lower half of a 64-byte word
  logic       end_half;
  logic [1:0] axi_len;

  assign inc = req.ftran & req.ltran & req.size[0] & req.swizzle;

  // bit 5 of the start address, the odd 32B slot
  assign stt_half = req.addr[5];

  // low bit of (addr[7:5] + size) decides end alignment
  assign end_half = ~(req.addr[5] ^ req.size[0]);

  // beats minus one, size counts 32B atoms minus one
  assign axi_len = req.size[2:1] + {1'b0, inc};

  // ======================================================================
  // AXI command
  // ======================================================================

  assign cmd.axid = req.axid;
  // drop the atom offset
  assign cmd.addr = {req.addr[mem_addr_width-1:atom_log2], {atom_log2{1'b0}}};
  assign cmd.len  = axi_len;

  // ======================================================================
  // context queue entry
  // ======================================================================

  assign cq_entry.lens    = axi_len;
  assign cq_entry.swizzle = req.swizzle;
  assign cq_entry.odd     = req.odd;
  assign cq_entry.ltran   = req.ltran;

  // first beat carries an unwanted lower half
  assign cq_entry.fdrop = req.ftran & stt_half & half_atom_en;

  // last beat carries an unwanted upper half
  assign cq_entry.ldrop = req.ltran & end_half & half_atom_en;

  // ======================================================================
  // thread id lookup
  // ======================================================================

  // reverse scan so the lowest matching index wins
  // unknown ids fall back to thread 0
  always_comb begin
    thread_id = '0;
    for (int i = num_read_clients - 1; i >= 0; i--) begin
      if (req.axid == client_axid_table[i]) begin
        thread_id = thread_id_width'(i);
      end
    end
  end

endmodule

// File: nocif_read_ig_cvt.f
+incdir+test
hw/nocif_read_pkg.sv
hw/read_cmd_decode.sv
hw/os_credit_ctrl.sv
hw/ar_skid_pipe.sv
hw/nocif_read_ig_cvt.sv
test/tb_nocif_read_ig_cvt.sv

// File: run_sim.sh
#!/bin/sh
# build and run the read ingress converter testbench with Verilator
# exit status 0 only when the run prints the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_nocif_read_ig_cvt \
  -Mdir obj_dir \
  -f nocif_read_ig_cvt.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_nocif_read_ig_cvt 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
echo "pass message not found"
exit 1

// File: test/tb_read_model.svh
// reference model for the read ingress converter testbench
// included inside the testbench module, after nocif_read_pkg is imported
// requests are assumed to satisfy the stimulus constraints of the testbench

`ifndef TB_READ_MODEL_SVH
`define TB_READ_MODEL_SVH

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// single swizzled odd-size transfer needs one more beat
function automatic logic extra_beat(input rd_req_t r);
  return r.ftran && r.ltran && r.swizzle && r.size[0];
endfunction

// beats on the AXI side, one per 64-byte word touched
function automatic int beat_count(input rd_req_t r);
  return int'(r.size[2:1]) + (extra_beat(r) ? 1 : 0) + 1;
endfunction

function automatic axi_cmd_t expect_cmd(input rd_req_t r);
  axi_cmd_t c;
  c.axid = r.axid;
  c.addr = r.addr;
  // atom offset never reaches the bus
  c.addr[atom_log2-1:0] = '0;
  c.len = 2'(beat_count(r) - 1);
  return c;
endfunction

function automatic cq_entry_t expect_entry(input rd_req_t r, input bit half_en);
  cq_entry_t e;
  e.lens    = 2'(beat_count(r) - 1);
  e.swizzle = r.swizzle;
  e.odd     = r.odd;
  e.ltran   = r.ltran;
  // start in the upper 32B half drops the lower half of beat one
  e.fdrop = half_en && r.ftran && r.addr[5];
  // end in the lower 32B half drops the upper half of the last beat
  e.ldrop = half_en && r.ltran && (r.addr[5] == r.size[0]);
  return e;
endfunction

// first table match, unknown ids map to thread 0
function automatic logic [thread_id_width-1:0] expect_thread(input rd_req_t r);
  for (int i = 0; i < num_read_clients; i++) begin
    if (client_axid_table[i] == r.axid) begin
      return thread_id_width'(i);
    end
  end
  return '0;
endfunction

// limit is the register value plus one beat
function automatic bit would_be_full(input int cnt, input bit vld, input int beats,
                                     input int eg_d, input int limit);
  return (cnt + (vld ? beats : 0) - eg_d) > (limit + 1);
endfunction

`endif

// File: test/tb_nocif_read_ig_cvt.sv
// random traffic testbench for the read ingress converter
// 400 requests with the outstanding limit redrawn every 100 of them
// the limit register never drops below 3
// egress pulses never outrun the beats already accepted

module tb_nocif_read_ig_cvt
  import nocif_read_pkg::*;
();

  localparam int  clk_period     = 40;
  localparam int  drive_delay    = 2;
  localparam int  reset_cycles   = 8;
  localparam int  num_requests   = 400;
  localparam int  run_len        = 100;
  localparam int  drain_cycles   = 4;
  localparam int  timeout_cycles = num_requests * 40;
  localparam bit  half_atom      = 1'b1;

  logic nvdla_core_clk;
  logic nvdla_core_rstn;
  logic req_valid;
  logic req_ready;
  rd_req_t req_pd;
  logic cq_pvld;
  logic cq_prdy;
  logic [thread_id_width-1:0] cq_tid;
  cq_entry_t cq_pd;
  logic arvalid;
  logic arready;
  logic [7:0] arid;
  logic [mem_addr_width-1:0] araddr;
  logic [3:0] arlen;
  logic eg_vld;
  logic [7:0] os_limit;

  // ======================================================================
  // model state and scoreboard
  // ======================================================================

  logic [31:0] lfsr_state = 32'h3ee70ccf;
  int model_cnt = 0;
  int model_eg_d = 0;
  int issued_beats = 0;
  int returned_beats = 0;
  int sent = 0;
  int accepted = 0;
  int ar_beats = 0;
  int cycle_cnt = 0;
  bit req_taken = 1'b0;
  bit monitor_on = 1'b0;
  axi_cmd_t ar_queue[$];
  rd_req_t mon_req;
  int mon_beats;
  bit mon_full;
  bit mon_taken;
  axi_cmd_t mon_exp;

  `include "tb_read_model.svh"

  nocif_read_ig_cvt #(
    .half_atom_en (half_atom)
  ) dut0 (
    .nvdla_core_clk          (nvdla_core_clk),
    .nvdla_core_rstn         (nvdla_core_rstn),
    .spt2cvt_req_valid       (req_valid),
    .spt2cvt_req_ready       (req_ready),
    .spt2cvt_req_pd          (req_pd),
    .cq_wr_pvld              (cq_pvld),
    .cq_wr_prdy              (cq_prdy),
    .cq_wr_thread_id         (cq_tid),
    .cq_wr_pd                (cq_pd),
    .mcif2noc_axi_ar_arvalid (arvalid),
    .mcif2noc_axi_ar_arready (arready),
    .mcif2noc_axi_ar_arid    (arid),
    .mcif2noc_axi_ar_araddr  (araddr),
    .mcif2noc_axi_ar_arlen   (arlen),
    .eg2ig_axi_vld           (eg_vld),
    .reg2dp_rd_os_cnt        (os_limit)
  );

  always #(clk_period / 2) nvdla_core_clk = ~nvdla_core_clk;

  // n fresh bits with the lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped on error");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("FAILED at %0t: %s", $time, msg));
  endtask

  // aligned request inside one 256-byte block and at most four beats
  function automatic rd_req_t random_request();
    rd_req_t r;
    logic [2:0] blk;
    logic [27:0] hi;
    logic [27:0] lo;
    r.axid    = 4'(rand_bits(4));
    r.ftran   = 1'(rand_bits(1));
    r.ltran   = 1'(rand_bits(1));
    r.odd     = 1'(rand_bits(1));
    r.swizzle = 1'(rand_bits(1));
    r.size    = 3'(rand_bits(3));
    blk       = 3'(rand_bits(3));
    hi        = 28'(rand_bits(28));
    lo        = 28'(rand_bits(28));
    if (int'(blk) + int'(r.size) > 7) begin
      blk = 3'(7 - int'(r.size));
    end
    r.addr = {hi, lo, blk, 5'b0};
    if (r.size[2:1] == 2'b11 && extra_beat(r)) begin
      r.swizzle = 1'b0;
    end
    return r;
  endfunction

  // ======================================================================
  // stimulus driven just after each rising edge
  // ======================================================================

  task automatic drive_cycle();
    bit want;
    // an offered request stays until taken
    if (!(req_valid && !req_taken)) begin
      req_pd = random_request();
      want = rand_bits(2) != 32'd0;
      req_valid = want && (sent < num_requests);
      if (req_valid) begin
        // new limit at the start of each run
        if (sent % run_len == 0) begin
          os_limit = 8'(3 + rand_bits(5));
        end
        sent++;
      end
    end
    cq_prdy = rand_bits(3) != 32'd0;
    arready = 1'(rand_bits(1));
    want = rand_bits(2) != 32'd0;
    eg_vld = want && (returned_beats < issued_beats);
    if (eg_vld) begin
      returned_beats++;
    end
  endtask

  // ======================================================================
  // monitor sampling on the falling edge
  // ======================================================================

  always @(negedge nvdla_core_clk) begin
    if (monitor_on) begin
      mon_req   = req_pd;
      mon_beats = beat_count(mon_req);
      mon_full  = would_be_full(model_cnt, req_valid, mon_beats, model_eg_d, int'(os_limit));
      if (mon_full) begin
        assert (!req_ready && !cq_pvld)
        else report_mismatch("request offered ready while outstanding limit is reached");
      end
      // AR beats are checked before this cycle's accept is queued
      if (arvalid && arready) begin
        if (ar_queue.size() == 0) begin
          abort_run("AR beat appeared with no accepted request waiting for it");
        end else begin
          mon_exp = ar_queue.pop_front();
          assert (arid == {4'b0, mon_exp.axid} && araddr == mon_exp.addr
                  && arlen == {2'b0, mon_exp.len})
          else report_mismatch($sformatf("AR id %h addr %h len %h, expected %h %h %h",
                                         arid, araddr, arlen, mon_exp.axid,
                                         mon_exp.addr, mon_exp.len));
          ar_beats++;
        end
      end
      if (cq_pvld && cq_prdy) begin
        assert (req_ready) else report_mismatch("context write without request ready");
        assert (cq_pd == expect_entry(mon_req, half_atom))
        else report_mismatch($sformatf("cq entry %h, expected %h", cq_pd,
                                       expect_entry(mon_req, half_atom)));
        assert (cq_tid == expect_thread(mon_req))
        else report_mismatch($sformatf("thread id %0d, expected %0d", cq_tid,
                                       expect_thread(mon_req)));
      end
      mon_taken = req_valid && req_ready;
      if (mon_taken) begin
        assert (cq_pvld && cq_prdy) else report_mismatch("accept without context write");
        ar_queue.push_back(expect_cmd(mon_req));
        model_cnt += mon_beats;
        issued_beats += mon_beats;
        accepted++;
      end
      // credit comes back one cycle after the pulse
      model_cnt -= model_eg_d;
      model_eg_d = eg_vld ? 1 : 0;
      req_taken = mon_taken;
    end
  end

  always @(posedge nvdla_core_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      abort_run($sformatf("timeout, run not finished after %0d cycles", cycle_cnt));
    end
  end

  initial begin
    nvdla_core_clk  = 1'b0;
    nvdla_core_rstn = 1'b0;
    req_valid = 1'b0;
    req_pd    = '0;
    cq_prdy   = 1'b0;
    arready   = 1'b0;
    eg_vld    = 1'b0;
    os_limit  = 8'd3;
    repeat (reset_cycles) @(posedge nvdla_core_clk);
    #drive_delay nvdla_core_rstn = 1'b1;
    // quiet outputs before the first request
    repeat (2) begin
      @(negedge nvdla_core_clk);
      assert (!arvalid && !cq_pvld) else report_mismatch("AR or cq valid high after reset");
    end
    monitor_on = 1'b1;
    while (accepted < num_requests || ar_queue.size() != 0) begin
      @(posedge nvdla_core_clk);
      #drive_delay drive_cycle();
    end
    // idle tail with arready held high so a repeated AR beat still shows
    repeat (drain_cycles) begin
      @(posedge nvdla_core_clk);
      #drive_delay drive_cycle();
      arready = 1'b1;
    end
    if (ar_beats == accepted && accepted == num_requests) begin
      $display("Simulation passed");
      $finish;
    end else begin
      report_mismatch($sformatf("%0d AR beats for %0d accepted requests", ar_beats, accepted));
    end
  end

endmodule
